// ==== src/vmul_pkg.sv ====
/*
 * vmul_pkg
 * widths, vector types and opcode fields shared by the vector integer multiply unit
 */
package vmul_pkg;

  ////////////////////////////////////////////////////////////
  // widths and vector types
  localparam int VLEN            = 128;
  localparam int XLEN            = 32;
  localparam int BYTE_LANES      = VLEN / 8;
  localparam int NUM_MUL8        = 64;  // four 4x4 tiles
  localparam int ROB_DEPTH_WIDTH = 4;

  typedef logic [VLEN-1:0]            vreg_t;
  typedef logic [2*VLEN-1:0]          wide_t;       // double-width element products
  typedef logic [XLEN-1:0]            xreg_t;
  typedef logic [ROB_DEPTH_WIDTH-1:0] rob_entry_t;
  typedef logic [BYTE_LANES-1:0]      byte_mask_t;  // one bit per byte lane
  typedef logic [15:0]                pp_t;         // 8x8 partial product
  typedef pp_t [NUM_MUL8-1:0]         pp_array_t;

  ////////////////////////////////////////////////////////////
  // instruction fields
  typedef logic [5:0] funct6_t;
  typedef logic [2:0] funct3_t;

  localparam funct3_t OPIVV = 3'b000;
  localparam funct3_t OPMVV = 3'b010;
  localparam funct3_t OPIVX = 3'b100;
  localparam funct3_t OPMVX = 3'b110;

  localparam funct6_t VMULHU  = 6'b100100;
  localparam funct6_t VMUL    = 6'b100101;
  localparam funct6_t VMULHSU = 6'b100110;
  localparam funct6_t VMULH   = 6'b100111;
  localparam funct6_t VSMUL   = 6'b100111;  // OPI space, same code as vmulh
  localparam funct6_t VWMULU  = 6'b111000;
  localparam funct6_t VWMULSU = 6'b111010;
  localparam funct6_t VWMUL   = 6'b111011;

  ////////////////////////////////////////////////////////////
  // element width, anything else runs as EEW8
  typedef logic [2:0] eew_t;

  localparam eew_t EEW8  = 3'd0;
  localparam eew_t EEW16 = 3'd1;
  localparam eew_t EEW32 = 3'd2;

  // fixed-point rounding mode
  typedef logic [1:0] vxrm_t;

  localparam vxrm_t RNU = 2'd0;  // round to nearest up
  localparam vxrm_t RNE = 2'd1;  // round to nearest even
  localparam vxrm_t RDN = 2'd2;  // truncate
  localparam vxrm_t ROD = 2'd3;  // jam to odd

endpackage

// ==== src/vmul_decode.sv ====
/*
 * vmul_decode
 * turns funct3/funct6 into operand selection, signedness and result-form flags,
 * plus the per-byte sign masks for the byte multiplier array
 */
`timescale 1ns/1ps

module vmul_decode (
  input  logic                 uop_valid,
  input  vmul_pkg::funct6_t    funct6,
  input  vmul_pkg::funct3_t    funct3,
  input  vmul_pkg::eew_t       eew,
  input  vmul_pkg::vreg_t      vs1_data,
  input  vmul_pkg::vreg_t      vs2_data,
  input  vmul_pkg::xreg_t      rs1_data,
  input  logic                 uop_index,
  output vmul_pkg::vreg_t      src2,
  output vmul_pkg::vreg_t      src1,
  output vmul_pkg::byte_mask_t src2_sign_mask,
  output vmul_pkg::byte_mask_t src1_sign_mask,
  output logic                 src2_signed,
  output logic                 src1_signed,
  output logic                 is_widen,
  output logic                 keep_low,
  output logic                 is_vsmul
);

  localparam int HALF = vmul_pkg::VLEN / 2;

  logic                 opm;
  logic                 opi;
  logic                 scalar;
  logic                 high_op;
  vmul_pkg::vreg_t      bcast;
  vmul_pkg::byte_mask_t top_bytes;
  vmul_pkg::vreg_t      vs2_half;
  vmul_pkg::vreg_t      vs1_half;

  // opcode class
  always_comb begin
    opm      = uop_valid && (funct3 == vmul_pkg::OPMVV || funct3 == vmul_pkg::OPMVX);
    opi      = uop_valid && (funct3 == vmul_pkg::OPIVV || funct3 == vmul_pkg::OPIVX);
    scalar   = funct3 == vmul_pkg::OPMVX || funct3 == vmul_pkg::OPIVX;
    high_op  = funct6 inside {vmul_pkg::VMULH, vmul_pkg::VMULHU, vmul_pkg::VMULHSU};
    is_widen = opm && (funct6 inside {vmul_pkg::VWMUL, vmul_pkg::VWMULU, vmul_pkg::VWMULSU});
    is_vsmul = opi;  // whole OPI space maps to vsmul
    keep_low = opm && !is_widen && !high_op;  // unknown funct6 runs as vmul
    src2_signed = opi || (opm && !(funct6 inside {vmul_pkg::VMULHU, vmul_pkg::VWMULU}));
    src1_signed = opi || (opm && !(funct6 inside {vmul_pkg::VMULHU, vmul_pkg::VMULHSU,
                                                   vmul_pkg::VWMULU, vmul_pkg::VWMULSU}));
  end

  // scalar broadcast and element top-byte pattern
  always_comb begin
    case (eew)
      vmul_pkg::EEW16: begin
        bcast     = {8{rs1_data[15:0]}};
        top_bytes = 16'haaaa;
      end
      vmul_pkg::EEW32: begin
        bcast     = {4{rs1_data}};
        top_bytes = 16'h8888;
      end
      default: begin
        bcast     = {16{rs1_data[7:0]}};
        top_bytes = 16'hffff;
      end
    endcase
  end

  // widening takes one 64-bit half, zero-extended
  assign vs2_half = uop_index ? {{HALF{1'b0}}, vs2_data[vmul_pkg::VLEN-1:HALF]}
                              : {{HALF{1'b0}}, vs2_data[HALF-1:0]};
  assign vs1_half = uop_index ? {{HALF{1'b0}}, vs1_data[vmul_pkg::VLEN-1:HALF]}
                              : {{HALF{1'b0}}, vs1_data[HALF-1:0]};

  always_comb begin
    src2 = '0;
    src1 = '0;
    if (opm || opi) begin
      src2 = is_widen ? vs2_half : vs2_data;
      if (scalar) begin
        src1 = bcast;
      end else begin
        src1 = is_widen ? vs1_half : vs1_data;
      end
    end
  end

  assign src2_sign_mask = src2_signed ? top_bytes : '0;
  assign src1_sign_mask = src1_signed ? top_bytes : '0;

endmodule

// ==== src/vmul_array.sv ====
/*
 * vmul_array
 * 64 signed/unsigned 8x8 byte multipliers in four 4x4 tiles, one per 32-bit group,
 * followed by the single pipeline register for products and control
 */
`timescale 1ns/1ps

module vmul_array (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 uop_valid,
  input  vmul_pkg::rob_entry_t rob_entry,
  input  vmul_pkg::eew_t       eew,
  input  vmul_pkg::vxrm_t      vxrm,
  input  vmul_pkg::vreg_t      src2,
  input  vmul_pkg::vreg_t      src1,
  input  vmul_pkg::byte_mask_t src2_sign_mask,
  input  vmul_pkg::byte_mask_t src1_sign_mask,
  input  logic                 src2_signed,
  input  logic                 src1_signed,
  input  logic                 is_widen,
  input  logic                 keep_low,
  input  logic                 is_vsmul,
  output logic                 valid_d1,
  output vmul_pkg::rob_entry_t rob_entry_d1,
  output vmul_pkg::eew_t       eew_d1,
  output vmul_pkg::vxrm_t      vxrm_d1,
  output vmul_pkg::pp_array_t  products_d1,
  output logic                 src2_signed_d1,
  output logic                 src1_signed_d1,
  output logic                 is_widen_d1,
  output logic                 keep_low_d1,
  output logic                 is_vsmul_d1
);

  vmul_pkg::pp_array_t products;

  ////////////////////////////////////////////////////////////
  // byte multipliers, product index is z*16 + y*4 + x
  for (genvar z = 0; z < 4; z++) begin : g_tile
    for (genvar y = 0; y < 4; y++) begin : g_row
      for (genvar x = 0; x < 4; x++) begin : g_col
        logic signed [8:0]  in2;
        logic signed [8:0]  in1;
        logic signed [17:0] prod;

        assign in2 = {src2_sign_mask[z*4+x] & src2[8*(z*4+x)+7], src2[8*(z*4+x) +: 8]};
        assign in1 = {src1_sign_mask[z*4+y] & src1[8*(z*4+y)+7], src1[8*(z*4+y) +: 8]};
        assign prod = in2 * in1;
        assign products[z*16+y*4+x] = prod[15:0];  // exact for all sign mixes
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_d1       <= 1'b0;
      rob_entry_d1   <= '0;
      eew_d1         <= '0;
      vxrm_d1        <= '0;
      products_d1    <= '0;
      src2_signed_d1 <= 1'b0;
      src1_signed_d1 <= 1'b0;
      is_widen_d1    <= 1'b0;
      keep_low_d1    <= 1'b0;
      is_vsmul_d1    <= 1'b0;
    end else begin
      valid_d1       <= uop_valid;
      rob_entry_d1   <= rob_entry;
      eew_d1         <= eew;
      vxrm_d1        <= vxrm;
      products_d1    <= products;
      src2_signed_d1 <= src2_signed;
      src1_signed_d1 <= src1_signed;
      is_widen_d1    <= is_widen;
      keep_low_d1    <= keep_low;
      is_vsmul_d1    <= is_vsmul;
    end
  end

endmodule

// ==== src/vmul_combine.sv ====
/*
 * vmul_combine
 * sums registered byte products into exact 2*SEW element products
 */
`timescale 1ns/1ps

module vmul_combine (
  input  vmul_pkg::eew_t      eew_d1,
  input  vmul_pkg::pp_array_t products_d1,
  input  logic                src2_signed_d1,
  input  logic                src1_signed_d1,
  output vmul_pkg::wide_t     full_product
);

  logic [63:0] elem_sum;

  // element of nbytes starting at byte lane base
  function automatic logic [63:0] elem_product(input vmul_pkg::pp_array_t pp,
                                               input int base, input int nbytes,
                                               input logic s2, input logic s1);
    logic [63:0] sum;
    logic [63:0] term;
    logic        ext;
    int          idx;
    sum = '0;
    for (int y = 0; y < 4; y++) begin
      for (int x = 0; x < 4; x++) begin
        if (x < nbytes && y < nbytes) begin
          idx  = (base / 4) * 16 + (base % 4 + y) * 4 + base % 4 + x;
          // a term is signed when it holds the top byte of a signed operand
          ext  = pp[idx][15] & (((x == nbytes - 1) & s2) | ((y == nbytes - 1) & s1));
          term = {{48{ext}}, pp[idx]};
          sum  = sum + (term << (8 * (x + y)));
        end
      end
    end
    return sum;
  endfunction

  always_comb begin
    full_product = '0;
    elem_sum     = '0;
    case (eew_d1)
      vmul_pkg::EEW16: begin
        for (int e = 0; e < 8; e++) begin
          elem_sum = elem_product(products_d1, 2 * e, 2, src2_signed_d1, src1_signed_d1);
          full_product[32*e +: 32] = elem_sum[31:0];
        end
      end
      vmul_pkg::EEW32: begin
        for (int e = 0; e < 4; e++) begin
          elem_sum = elem_product(products_d1, 4 * e, 4, src2_signed_d1, src1_signed_d1);
          full_product[64*e +: 64] = elem_sum;
        end
      end
      default: begin
        for (int e = 0; e < 16; e++) begin
          full_product[16*e +: 16] = products_d1[(e / 4) * 16 + (e % 4) * 5];  // diagonal
        end
      end
    endcase
  end

endmodule

// ==== src/vmul_result.sv ====
/*
 * vmul_result
 * picks low, high, widened or rounded-and-saturated vsmul form per element,
 * and raises vxsat when a vsmul element saturates
 */
`timescale 1ns/1ps

module vmul_result (
  input  vmul_pkg::eew_t  eew_d1,
  input  vmul_pkg::vxrm_t vxrm_d1,
  input  vmul_pkg::wide_t full_product,
  input  logic            is_widen_d1,
  input  logic            keep_low_d1,
  input  logic            is_vsmul_d1,
  output vmul_pkg::vreg_t result_data,
  output logic            result_vxsat
);

  vmul_pkg::vreg_t [2:0] narrow_data;  // one per element width
  logic [2:0]            any_sat;
  vmul_pkg::vreg_t       sel_data;
  logic                  sel_sat;

  ////////////////////////////////////////////////////////////
  // per element width g: SEW = 8, 16, 32
  for (genvar g = 0; g < 3; g++) begin : g_sew
    localparam int SEW = 8 << g;
    localparam int NE  = vmul_pkg::VLEN / SEW;

    logic [NE-1:0] sat_flags;

    for (genvar k = 0; k < NE; k++) begin : g_elem
      logic [2*SEW-1:0] prod;
      logic             rnd;
      logic [SEW-1:0]   vsmul_val;

      assign prod = full_product[2*SEW*k +: 2*SEW];

      // rounding increment after shifting right by SEW-1
      always_comb begin
        case (vxrm_d1)
          vmul_pkg::RNU: rnd = prod[SEW-2];
          vmul_pkg::RNE: rnd = prod[SEW-2] & ((|prod[SEW-3:0]) | prod[SEW-1]);
          vmul_pkg::RDN: rnd = 1'b0;
          vmul_pkg::ROD: rnd = ~prod[SEW-1] & (|prod[SEW-2:0]);
        endcase
      end

      assign sat_flags[k] = prod[2*SEW-1 -: 2] == 2'b01;  // only min*min gets here
      assign vsmul_val = sat_flags[k] ? {1'b0, {(SEW-1){1'b1}}}
                                      : prod[SEW-1 +: SEW] + {{(SEW-1){1'b0}}, rnd};
      assign narrow_data[g][SEW*k +: SEW] = is_vsmul_d1 ? vsmul_val
                                          : keep_low_d1 ? prod[SEW-1:0]
                                          : prod[2*SEW-1 -: SEW];
    end

    assign any_sat[g] = |sat_flags;
  end

  ////////////////////////////////////////////////////////////
  always_comb begin
    case (eew_d1)
      vmul_pkg::EEW16: begin
        sel_data = narrow_data[1];
        sel_sat  = any_sat[1];
      end
      vmul_pkg::EEW32: begin
        sel_data = narrow_data[2];
        sel_sat  = any_sat[2];
      end
      default: begin
        sel_data = narrow_data[0];
        sel_sat  = any_sat[0];
      end
    endcase
  end

  assign result_data  = is_widen_d1 ? full_product[vmul_pkg::VLEN-1:0] : sel_data;
  assign result_vxsat = is_vsmul_d1 & sel_sat;  // never set outside vsmul

endmodule

// ==== src/vmul_unit.sv ====
/*
 * vmul_unit
 * two-stage vector integer multiply unit, one micro-op in per cycle and its
 * result one cycle later with the ROB tag
 */
`timescale 1ns/1ps

module vmul_unit (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 uop_valid,
  input  vmul_pkg::rob_entry_t rob_entry,
  input  vmul_pkg::funct6_t    funct6,
  input  vmul_pkg::funct3_t    funct3,
  input  vmul_pkg::vxrm_t      vxrm,
  input  vmul_pkg::eew_t       eew,
  input  vmul_pkg::vreg_t      vs1_data,
  input  vmul_pkg::vreg_t      vs2_data,
  input  vmul_pkg::xreg_t      rs1_data,
  input  logic                 uop_index,
  output logic                 result_valid,
  output vmul_pkg::rob_entry_t result_rob_entry,
  output vmul_pkg::vreg_t      result_data,
  output logic                 result_vxsat
);

  // decode to array
  vmul_pkg::vreg_t      src2;
  vmul_pkg::vreg_t      src1;
  vmul_pkg::byte_mask_t src2_sign_mask;
  vmul_pkg::byte_mask_t src1_sign_mask;
  logic                 src2_signed;
  logic                 src1_signed;
  logic                 is_widen;
  logic                 keep_low;
  logic                 is_vsmul;

  // stage one
  vmul_pkg::eew_t       eew_d1;
  vmul_pkg::vxrm_t      vxrm_d1;
  vmul_pkg::pp_array_t  products_d1;
  logic                 src2_signed_d1;
  logic                 src1_signed_d1;
  logic                 is_widen_d1;
  logic                 keep_low_d1;
  logic                 is_vsmul_d1;
  vmul_pkg::wide_t      full_product;

  vmul_decode u_decode (
    .uop_valid      (uop_valid),
    .funct6         (funct6),
    .funct3         (funct3),
    .eew            (eew),
    .vs1_data       (vs1_data),
    .vs2_data       (vs2_data),
    .rs1_data       (rs1_data),
    .uop_index      (uop_index),
    .src2           (src2),
    .src1           (src1),
    .src2_sign_mask (src2_sign_mask),
    .src1_sign_mask (src1_sign_mask),
    .src2_signed    (src2_signed),
    .src1_signed    (src1_signed),
    .is_widen       (is_widen),
    .keep_low       (keep_low),
    .is_vsmul       (is_vsmul)
  );

  vmul_array u_array (
    .clk            (clk),
    .arst_n         (arst_n),
    .uop_valid      (uop_valid),
    .rob_entry      (rob_entry),
    .eew            (eew),
    .vxrm           (vxrm),
    .src2           (src2),
    .src1           (src1),
    .src2_sign_mask (src2_sign_mask),
    .src1_sign_mask (src1_sign_mask),
    .src2_signed    (src2_signed),
    .src1_signed    (src1_signed),
    .is_widen       (is_widen),
    .keep_low       (keep_low),
    .is_vsmul       (is_vsmul),
    .valid_d1       (result_valid),      // straight to the ROB
    .rob_entry_d1   (result_rob_entry),
    .eew_d1         (eew_d1),
    .vxrm_d1        (vxrm_d1),
    .products_d1    (products_d1),
    .src2_signed_d1 (src2_signed_d1),
    .src1_signed_d1 (src1_signed_d1),
    .is_widen_d1    (is_widen_d1),
    .keep_low_d1    (keep_low_d1),
    .is_vsmul_d1    (is_vsmul_d1)
  );

  vmul_combine u_combine (
    .eew_d1         (eew_d1),
    .products_d1    (products_d1),
    .src2_signed_d1 (src2_signed_d1),
    .src1_signed_d1 (src1_signed_d1),
    .full_product   (full_product)
  );

  vmul_result u_result (
    .eew_d1       (eew_d1),
    .vxrm_d1      (vxrm_d1),
    .full_product (full_product),
    .is_widen_d1  (is_widen_d1),
    .keep_low_d1  (keep_low_d1),
    .is_vsmul_d1  (is_vsmul_d1),
    .result_data  (result_data),
    .result_vxsat (result_vxsat)
  );

endmodule

// ==== testbench/vmul_model.svh ====
/*
 * vmul reference model
 * expected data and vxsat of one micro-op, element by element,
 * with full-precision integers
 */
`ifndef VMUL_MODEL_SVH
`define VMUL_MODEL_SVH

function automatic int sew_bits(input vmul_pkg::eew_t ew);
  case (ew)
    vmul_pkg::EEW16: return 16;
    vmul_pkg::EEW32: return 32;
    default:         return 8;
  endcase
endfunction

// element k of a vector, zero-extended
function automatic logic [31:0] get_elem(input vmul_pkg::vreg_t v, input int sew, input int k);
  vmul_pkg::vreg_t shifted;
  logic [31:0]     mask;
  shifted = v >> (sew * k);
  mask    = 32'hffff_ffff >> (32 - sew);
  return shifted[31:0] & mask;
endfunction

function automatic logic signed [127:0] to_int(input logic [31:0] raw, input int sew,
                                               input logic sgn);
  logic signed [127:0] val;
  val = $signed({96'd0, raw});
  if (sgn && raw[sew-1]) begin
    val = val - (128'sd1 <<< sew);  // two's complement weight of the top bit
  end
  return val;
endfunction

function automatic void predict(input vmul_pkg::funct6_t f6, input vmul_pkg::funct3_t f3,
                                input vmul_pkg::vxrm_t rm, input vmul_pkg::eew_t ew,
                                input vmul_pkg::vreg_t v1, input vmul_pkg::vreg_t v2,
                                input vmul_pkg::xreg_t r1, input logic idx,
                                output vmul_pkg::vreg_t data, output logic sat);
  int                  sew;
  int                  nelem;
  logic                scalar;
  logic                vsmul;
  logic                widen;
  logic                high;
  logic                s2;
  logic                s1;
  logic                rbit;
  logic signed [127:0] a;
  logic signed [127:0] b;
  logic signed [127:0] p;
  logic signed [127:0] r;
  logic signed [127:0] inc;
  logic signed [127:0] min_val;
  logic [127:0]        keep;
  vmul_pkg::vreg_t     src2;
  vmul_pkg::vreg_t     src1;
  sew    = sew_bits(ew);
  scalar = f3 == vmul_pkg::OPMVX || f3 == vmul_pkg::OPIVX;
  vsmul  = f3 == vmul_pkg::OPIVV || f3 == vmul_pkg::OPIVX;
  widen  = 1'b0;
  high   = 1'b0;
  s2     = 1'b1;
  s1     = 1'b1;
  if (!vsmul) begin
    case (f6)
      vmul_pkg::VMULH:   high = 1'b1;
      vmul_pkg::VMULHU:  {high, s2, s1} = 3'b100;
      vmul_pkg::VMULHSU: {high, s1} = 2'b10;
      vmul_pkg::VWMUL:   widen = 1'b1;
      vmul_pkg::VWMULU:  {widen, s2, s1} = 3'b100;
      vmul_pkg::VWMULSU: {widen, s1} = 2'b10;
      default: ;         // plain vmul
    endcase
  end
  src2    = (widen && idx) ? v2 >> 64 : v2;
  src1    = (widen && idx) ? v1 >> 64 : v1;
  nelem   = widen ? 64 / sew : 128 / sew;
  min_val = -(128'sd1 <<< (sew - 1));
  data    = '0;
  sat     = 1'b0;
  for (int k = 0; k < nelem; k++) begin
    a = to_int(get_elem(src2, sew, k), sew, s2);
    b = scalar ? to_int(get_elem({96'd0, r1}, sew, 0), sew, s1)
               : to_int(get_elem(src1, sew, k), sew, s1);
    p = a * b;
    if (widen) begin
      keep = (128'd1 << (2 * sew)) - 128'd1;
      data = data | ((p & keep) << (2 * sew * k));
    end else begin
      if (vsmul && a == min_val && b == min_val) begin
        r   = (128'sd1 <<< (sew - 1)) - 128'sd1;  // largest positive element
        sat = 1'b1;
      end else if (vsmul) begin
        r    = p >>> (sew - 1);
        rbit = 1'b0;
        case (rm)
          vmul_pkg::RNU: rbit = p[sew-2];
          vmul_pkg::RNE: rbit = p[sew-2] & ((|(p & ((128'd1 << (sew - 2)) - 128'd1))) | p[sew-1]);
          vmul_pkg::ROD: r[0] = r[0] | (|(p & ((128'd1 << (sew - 1)) - 128'd1)));
          default: ;     // RDN truncates
        endcase
        inc = {127'd0, rbit};
        r   = r + inc;
      end else begin
        r = high ? p >>> sew : p;
      end
      keep = (128'd1 << sew) - 128'd1;
      data = data | ((r & keep) << (sew * k));
    end
  end
endfunction

`endif

// ==== testbench/vmul_tb.sv ====
/*
 * vmul_tb
 * directed and random micro-ops through the vector multiply unit,
 * each result checked against the reference model one cycle after issue
 */
`timescale 1ns/1ps

module vmul_tb;

  `include "vmul_model.svh"

  localparam int NUM_RANDOM = 1000;
  localparam int MAX_CYCLES = 3000;  // about twice the ~1300 issued cycles

  localparam vmul_pkg::eew_t    EEWS [3]      = '{vmul_pkg::EEW8, vmul_pkg::EEW16,
                                                  vmul_pkg::EEW32};
  localparam vmul_pkg::funct6_t MUL_OPS [4]   = '{vmul_pkg::VMUL, vmul_pkg::VMULH,
                                                  vmul_pkg::VMULHU, vmul_pkg::VMULHSU};
  localparam vmul_pkg::funct6_t WIDEN_OPS [3] = '{vmul_pkg::VWMUL, vmul_pkg::VWMULU,
                                                  vmul_pkg::VWMULSU};

  logic                 clk;
  logic                 arst_n;
  logic                 uop_valid;
  vmul_pkg::rob_entry_t rob_entry;
  vmul_pkg::funct6_t    funct6;
  vmul_pkg::funct3_t    funct3;
  vmul_pkg::vxrm_t      vxrm;
  vmul_pkg::eew_t       eew;
  vmul_pkg::vreg_t      vs1_data;
  vmul_pkg::vreg_t      vs2_data;
  vmul_pkg::xreg_t      rs1_data;
  logic                 uop_index;
  logic                 result_valid;
  vmul_pkg::rob_entry_t result_rob_entry;
  vmul_pkg::vreg_t      result_data;
  logic                 result_vxsat;

  vmul_pkg::vreg_t      exp_data_q [$];
  logic                 exp_sat_q [$];
  vmul_pkg::rob_entry_t exp_tag_q [$];
  vmul_pkg::vreg_t      exp_data;
  logic                 exp_sat;
  vmul_pkg::rob_entry_t exp_tag;
  vmul_pkg::rob_entry_t next_tag;
  logic                 issued_d1;
  int                   cycle_count;
  int                   valid_errors;
  int                   tag_errors;
  int                   data_errors;
  int                   sat_errors;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  vmul_unit i_dut (
    .clk(clk), .arst_n(arst_n), .uop_valid(uop_valid), .rob_entry(rob_entry),
    .funct6(funct6), .funct3(funct3), .vxrm(vxrm), .eew(eew),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .rs1_data(rs1_data), .uop_index(uop_index),
    .result_valid(result_valid), .result_rob_entry(result_rob_entry),
    .result_data(result_data), .result_vxsat(result_vxsat)
  );

  ////////////////////////////////////////////////////////////
  // stimulus helpers, called 2 ns after a rising edge
  task automatic issue(input vmul_pkg::funct6_t f6, input vmul_pkg::funct3_t f3,
                       input vmul_pkg::eew_t ew, input vmul_pkg::vxrm_t rm,
                       input vmul_pkg::vreg_t v1, input vmul_pkg::vreg_t v2,
                       input vmul_pkg::xreg_t r1, input logic idx);
    vmul_pkg::vreg_t d;
    logic            s;
    predict(f6, f3, rm, ew, v1, v2, r1, idx, d, s);
    uop_valid = 1'b1;
    rob_entry = next_tag;
    funct6    = f6;
    funct3    = f3;
    eew       = ew;
    vxrm      = rm;
    vs1_data  = v1;
    vs2_data  = v2;
    rs1_data  = r1;
    uop_index = idx;
    exp_data_q.push_back(d);
    exp_sat_q.push_back(s);
    exp_tag_q.push_back(next_tag);
    next_tag++;
    @(posedge clk);
    #2;
  endtask

  task automatic idle_cycle();
    uop_valid = 1'b0;
    @(posedge clk);
    #2;
  endtask

  function automatic vmul_pkg::vreg_t min_pattern(input vmul_pkg::eew_t ew);
    case (ew)
      vmul_pkg::EEW16: return {8{16'h8000}};
      vmul_pkg::EEW32: return {4{32'h8000_0000}};
      default:         return {16{8'h80}};
    endcase
  endfunction

  // mostly random, sometimes all ones or most negative
  function automatic vmul_pkg::vreg_t pick_vec(input vmul_pkg::eew_t ew);
    int kind;
    kind = $urandom_range(0, 5);
    case (kind)
      0:       return '1;
      1:       return min_pattern(ew);
      default: return {$urandom, $urandom, $urandom, $urandom};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // checking
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issued_d1 <= 1'b0;
    end else begin
      issued_d1 <= uop_valid;
    end
  end

  valid_follows_issue: assert property (@(posedge clk) disable iff (!arst_n)
                                        result_valid == issued_d1)
    else begin
      valid_errors++;
      $display("ERROR %0t result_valid expected %0b got %0b", $time, $sampled(issued_d1),
               $sampled(result_valid));
    end

  always @(negedge clk) begin
    if (!arst_n) begin
      assert (!result_valid) else begin
        valid_errors++;
        $display("ERROR %0t result_valid expected 0 got %0b", $time, result_valid);
      end
    end else if (result_valid) begin
      if (exp_tag_q.size() == 0) begin
        valid_errors++;
        $display("%0t: result_valid is high with no micro-op outstanding", $time);
      end else begin
        exp_tag  = exp_tag_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_sat  = exp_sat_q.pop_front();
        assert (result_rob_entry == exp_tag) else begin
          tag_errors++;
          $display("ERROR %0t result_rob_entry expected %h got %h", $time, exp_tag,
                   result_rob_entry);
        end
        assert (result_data == exp_data) else begin
          data_errors++;
          $display("ERROR %0t result_data expected %h got %h", $time, exp_data, result_data);
        end
        assert (result_vxsat == exp_sat) else begin
          sat_errors++;
          $display("ERROR %0t result_vxsat expected %0b got %0b", $time, exp_sat,
                   result_vxsat);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d results still outstanding", cycle_count,
               exp_tag_q.size());
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  initial begin
    vmul_pkg::vreg_t   mn;
    vmul_pkg::funct6_t f6;
    vmul_pkg::funct3_t f3;
    vmul_pkg::eew_t    ew;
    int                op;
    void'($urandom(32'h23d8_c5a9));
    arst_n       = 1'b0;
    uop_valid    = 1'b1;  // reset alone must keep result_valid low
    rob_entry    = '0;
    funct6       = '0;
    funct3       = '0;
    vxrm         = '0;
    eew          = '0;
    vs1_data     = '0;
    vs2_data     = '0;
    rs1_data     = '0;
    uop_index    = 1'b0;
    next_tag     = '0;
    cycle_count  = 0;
    valid_errors = 0;
    tag_errors   = 0;
    data_errors  = 0;
    sat_errors   = 0;
    repeat (5) @(posedge clk);
    #2;
    uop_valid = 1'b0;
    arst_n    = 1'b1;
    repeat (3) idle_cycle();  // nothing issued yet

    // low and high halves, vector and scalar forms
    for (int e = 0; e < 3; e++) begin
      mn = min_pattern(EEWS[e]);
      for (int o = 0; o < 4; o++) begin
        for (int vx = 0; vx < 2; vx++) begin
          f3 = (vx == 1) ? vmul_pkg::OPMVX : vmul_pkg::OPMVV;
          issue(MUL_OPS[o], f3, EEWS[e], vmul_pkg::RNU, pick_vec(EEWS[e]),
                pick_vec(EEWS[e]), $urandom, 1'b0);
          issue(MUL_OPS[o], f3, EEWS[e], vmul_pkg::RNU, '1, '1, '1, 1'b0);
          issue(MUL_OPS[o], f3, EEWS[e], vmul_pkg::RNU, mn, mn, mn[31:0], 1'b0);
        end
      end
    end

    // widening, both source halves
    for (int e = 0; e < 3; e++) begin
      for (int o = 0; o < 3; o++) begin
        for (int idx = 0; idx < 2; idx++) begin
          issue(WIDEN_OPS[o], vmul_pkg::OPMVV, EEWS[e], vmul_pkg::RNU, pick_vec(EEWS[e]),
                pick_vec(EEWS[e]), $urandom, idx == 1);
          issue(WIDEN_OPS[o], vmul_pkg::OPMVX, EEWS[e], vmul_pkg::RNU, pick_vec(EEWS[e]),
                pick_vec(EEWS[e]), $urandom, idx == 1);
        end
      end
    end

    // vsmul rounding and saturation, gapped issue
    for (int e = 0; e < 3; e++) begin
      mn = min_pattern(EEWS[e]);
      for (int rm = 0; rm < 4; rm++) begin
        issue(vmul_pkg::VSMUL, vmul_pkg::OPIVV, EEWS[e], 2'(rm), pick_vec(EEWS[e]),
              pick_vec(EEWS[e]), $urandom, 1'b0);
        issue(vmul_pkg::VSMUL, vmul_pkg::OPIVX, EEWS[e], 2'(rm), mn, mn, mn[31:0], 1'b0);
        idle_cycle();
        issue(vmul_pkg::VSMUL, vmul_pkg::OPIVV, EEWS[e], 2'(rm), mn, mn, mn[31:0], 1'b0);
      end
      // same operands, no vsmul, so no vxsat
      issue(vmul_pkg::VMULH, vmul_pkg::OPMVV, EEWS[e], vmul_pkg::RNU, mn, mn, mn[31:0], 1'b0);
      issue(vmul_pkg::VMUL, vmul_pkg::OPMVX, EEWS[e], vmul_pkg::RNU, mn, mn, mn[31:0], 1'b0);
    end

    // random mix with random gaps
    for (int n = 0; n < NUM_RANDOM; n++) begin
      if ($urandom_range(0, 3) == 0) begin
        idle_cycle();
      end
      op = $urandom_range(0, 7);
      ew = EEWS[$urandom_range(0, 2)];
      if (op == 7) begin
        f6 = vmul_pkg::VSMUL;
        f3 = ($urandom_range(0, 1) == 1) ? vmul_pkg::OPIVX : vmul_pkg::OPIVV;
      end else begin
        f6 = (op < 4) ? MUL_OPS[op] : WIDEN_OPS[op-4];
        f3 = ($urandom_range(0, 1) == 1) ? vmul_pkg::OPMVX : vmul_pkg::OPMVV;
      end
      issue(f6, f3, ew, 2'($urandom_range(0, 3)), pick_vec(ew), pick_vec(ew), $urandom,
            $urandom_range(0, 1) == 1);
    end

    idle_cycle();
    while (exp_tag_q.size() != 0) begin
      idle_cycle();
    end
    repeat (2) idle_cycle();
    $display("error counts: valid %0d, tag %0d, data %0d, vxsat %0d", valid_errors,
             tag_errors, data_errors, sat_errors);
    if (valid_errors + tag_errors + data_errors + sat_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== vmul.f ====
+incdir+testbench
src/vmul_pkg.sv
src/vmul_decode.sv
src/vmul_array.sv
src/vmul_combine.sv
src/vmul_result.sv
src/vmul_unit.sv
testbench/vmul_tb.sv

// ==== Makefile ====
# Verilator build and run of the vector multiply unit testbench

TOP := vmul_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f vmul.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf $(OBJ) sim.log
